// ==== vmem_share.f ====
+incdir+rtl
rtl/vmem_share_pkg.sv
rtl/scalar_lane_adapter.sv
rtl/data_arbiter.sv
rtl/resp_tracker.sv
rtl/vmem_share_top.sv
sim/tb_vmem_share.sv

// ==== Bender.yml ====
package:
  name: vmem_share

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vmem_share_pkg.sv
      - rtl/scalar_lane_adapter.sv
      - rtl/data_arbiter.sv
      - rtl/resp_tracker.sv
      - rtl/vmem_share_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_vmem_share.sv

// ==== sim/tb_vmem_share.sv ====
//////////////////////////////
// testbench for the shared data memory port
// random traffic, memory model and reference model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vmem_share_defines.svh"

module tb_vmem_share import vmem_share_pkg::*; ();

    localparam logic [31:0] SEED          = 32'h6919_90a4;
    localparam int unsigned N_TXN         = 400;
    localparam int unsigned RUN_TIMEOUT   = 10000;
    localparam int unsigned DRAIN_TIMEOUT = 500;

    // expected response, in grant order
    typedef struct packed {
        src_e   src;
        logic   we;
        logic   err;
        vid_t   id;
        vdata_t data;
    } exp_t;

    // response waiting inside the memory model
    typedef struct packed {
        vdata_t      data;
        logic        err;
        logic [31:0] due;
    } mem_resp_t;

    logic   clk_i, rst_ni;
    logic   s_req_i, s_we_i, s_gnt_o, s_rvalid_o, s_err_o;
    addr_t  s_addr_i;
    sbe_t   s_be_i;
    sdata_t s_wdata_i, s_rdata_o;
    logic   v_req_i, v_we_i, v_gnt_o, v_rvalid_o, v_err_o;
    addr_t  v_addr_i;
    vbe_t   v_be_i;
    vdata_t v_wdata_i, v_rdata_o;
    vid_t   v_id_i, v_id_o;
    logic   vec_pending_load_i, vec_pending_store_i;
    logic   mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i, mem_err_i;
    addr_t  mem_addr_o;
    vbe_t   mem_be_o;
    vdata_t mem_wdata_o, mem_rdata_i;

    logic [31:0] lfsr_state;
    logic [7:0]  mem_bytes [addr_t];
    logic [7:0]  ref_bytes [addr_t];
    exp_t        exp_q [$];
    mem_resp_t   mq [$];
    int unsigned cycles, issued, outstanding;
    logic        s_taken, v_taken, hit_full;

    vmem_share_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // unwritten bytes fold the whole address
    function automatic logic [7:0] fill_byte(input addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] peek(input bit use_ref, input addr_t a);
        if (use_ref) return ref_bytes.exists(a) ? ref_bytes[a] : fill_byte(a);
        return mem_bytes.exists(a) ? mem_bytes[a] : fill_byte(a);
    endfunction

    // error window is 0x10c0 to 0x10ff
    function automatic logic err_addr(input addr_t a);
        return a[7:6] == 2'b11;
    endfunction

    task automatic stop_failed(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input string got, input string exp);
        stop_failed($sformatf("mismatch at %0t: %s got %s expected %s", $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_scalar(input string name, input sdata_t got, input sdata_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_vector(input string name, input vdata_t got, input vdata_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_be(input string name, input vbe_t got, input vbe_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_id(input string name, input vid_t got, input vid_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    //////////////////////////////
    // per cycle stimulus
    //////////////////////////////

    task automatic drive_cycle();
        mem_resp_t m;
        cycles++;
        mem_rvalid_i = 1'b0;
        mem_err_i    = 1'b0;
        if (mq.size() != 0 && mq[0].due <= cycles) begin
            m            = mq.pop_front();
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = m.data;
            mem_err_i    = m.err;
        end
        mem_gnt_i = (rand_bits(2) != 0);
        // pending flags go quiet for the drain
        vec_pending_store_i = (issued < N_TXN) && (rand_bits(3) == 0);
        vec_pending_load_i  = (issued < N_TXN) && (rand_bits(2) == 0);
        if (s_taken) s_req_i = 1'b0;
        if (v_taken) v_req_i = 1'b0;
        s_taken = 1'b0;
        v_taken = 1'b0;
        if (!s_req_i && issued < N_TXN && rand_bits(1)) begin
            s_req_i   = 1'b1;
            s_addr_i  = 32'h1000 | (rand_bits(6) << 2);
            s_we_i    = rand_bits(1);
            s_be_i    = rand_bits(4);
            s_wdata_i = rand_bits(32);
            issued++;
        end
        if (!v_req_i && issued < N_TXN && rand_bits(2) == 0) begin
            v_req_i  = 1'b1;
            v_addr_i = 32'h1000 | (rand_bits(4) << 4);
            v_we_i   = rand_bits(1);
            v_be_i   = rand_bits(16);
            v_id_i   = v_id_i + 1'b1;
            for (int w = 0; w < `VMEM_W / 32; w++) v_wdata_i[w*32 +: 32] = rand_bits(32);
            issued++;
        end
    endtask

    //////////////////////////////
    // checks and models
    //////////////////////////////

    task automatic sample_cycle();
        exp_t      e;
        mem_resp_t m;
        vbe_t      exp_be;
        vdata_t    exp_wd;
        addr_t     base;
        logic      full;
        logic      hold;
        full = (outstanding == `MAX_OUTSTANDING);
        hold = v_req_i | vec_pending_store_i | (vec_pending_load_i & s_we_i);
        if (full && (s_req_i || v_req_i)) hit_full = 1'b1;
        check_flag("v_gnt_o", v_gnt_o, v_req_i & mem_gnt_i & ~full);
        check_flag("s_gnt_o", s_gnt_o, s_req_i & ~hold & mem_gnt_i & ~full);
        check_flag("mem_req_o", mem_req_o, (v_req_i | (s_req_i & ~hold)) & ~full);
        if (mem_rvalid_i) begin
            if (exp_q.size() == 0) stop_failed("memory response with nothing outstanding");
            e = exp_q.pop_front();
            check_flag("s_rvalid_o", s_rvalid_o, e.src == SRC_SCALAR);
            check_flag("v_rvalid_o", v_rvalid_o, e.src == SRC_VECTOR);
            if (e.src == SRC_VECTOR) begin
                check_flag("v_err_o", v_err_o, e.err);
                check_flag("s_err_o", s_err_o, 1'b0);
                check_id("v_id_o", v_id_o, e.id);
                if (!e.we) check_vector("v_rdata_o", v_rdata_o, e.data);
            end else begin
                check_flag("s_err_o", s_err_o, e.err);
                check_flag("v_err_o", v_err_o, 1'b0);
                if (!e.we) check_scalar("s_rdata_o", s_rdata_o, sdata_t'(e.data));
            end
            outstanding--;
        end else begin
            check_flag("s_rvalid_o", s_rvalid_o, 1'b0);
            check_flag("v_rvalid_o", v_rvalid_o, 1'b0);
        end
        if (s_gnt_o) begin
            // lane rule, address bits 3:2 pick the 32-bit lane
            for (int k = 0; k < `VMEM_W / 8; k++)
                exp_be[k] = (k / 4 == s_addr_i[3:2]) ? s_be_i[k % 4] : 1'b0;
            for (int l = 0; l < `VMEM_W / `SCALAR_W; l++) exp_wd[l*32 +: 32] = s_wdata_i;
            check_addr("mem_addr_o", mem_addr_o, s_addr_i);
            check_flag("mem_we_o", mem_we_o, s_we_i);
            check_be("mem_be_o", mem_be_o, exp_be);
            if (s_we_i) check_vector("mem_wdata_o", mem_wdata_o, exp_wd);
            base = s_addr_i & ~32'h3;
            e    = '{src: SRC_SCALAR, we: s_we_i, err: err_addr(s_addr_i), id: '0, data: '0};
            for (int k = 0; k < 4; k++) begin
                e.data[k*8 +: 8] = peek(1'b1, base + k);
                if (s_we_i && s_be_i[k]) ref_bytes[base + k] = s_wdata_i[k*8 +: 8];
            end
            exp_q.push_back(e);
            s_taken = 1'b1;
        end
        if (v_gnt_o) begin
            check_addr("mem_addr_o", mem_addr_o, v_addr_i);
            check_flag("mem_we_o", mem_we_o, v_we_i);
            check_be("mem_be_o", mem_be_o, v_be_i);
            if (v_we_i) check_vector("mem_wdata_o", mem_wdata_o, v_wdata_i);
            base = v_addr_i & ~32'hf;
            e    = '{src: SRC_VECTOR, we: v_we_i, err: err_addr(v_addr_i), id: v_id_i, data: '0};
            for (int k = 0; k < `VMEM_W / 8; k++) begin
                e.data[k*8 +: 8] = peek(1'b1, base + k);
                if (v_we_i && v_be_i[k]) ref_bytes[base + k] = v_wdata_i[k*8 +: 8];
            end
            exp_q.push_back(e);
            v_taken = 1'b1;
        end
        // memory side of the transfer, long delays in the second half
        if (mem_req_o && mem_gnt_i) begin
            base  = mem_addr_o & ~32'hf;
            m.err = err_addr(mem_addr_o);
            m.due = cycles + ((issued >= N_TXN / 2) ? 12 + rand_bits(3) : 1 + rand_bits(2));
            for (int k = 0; k < `VMEM_W / 8; k++) begin
                m.data[k*8 +: 8] = peek(1'b0, base + k);
                if (mem_we_o && mem_be_o[k]) mem_bytes[base + k] = mem_wdata_o[k*8 +: 8];
            end
            mq.push_back(m);
            outstanding++;
        end
    endtask

    task automatic step();
        @(negedge clk_i);
        drive_cycle();
        #1;
        sample_cycle();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin : main_seq
        int unsigned wait_cnt;
        lfsr_state = SEED;
        {s_req_i, s_we_i, s_addr_i, s_be_i, s_wdata_i} = '0;
        {v_req_i, v_we_i, v_addr_i, v_be_i, v_wdata_i, v_id_i} = '0;
        {vec_pending_load_i, vec_pending_store_i} = '0;
        {mem_gnt_i, mem_rvalid_i, mem_rdata_i, mem_err_i} = '0;
        {cycles, issued, outstanding} = '0;
        {s_taken, v_taken, hit_full} = '0;
        rst_ni = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        wait_cnt = 0;
        while (issued < N_TXN) begin
            if (wait_cnt == RUN_TIMEOUT) stop_failed("timeout while issuing requests");
            step();
            wait_cnt++;
        end
        // drain held requests and in-flight responses
        wait_cnt = 0;
        while (s_req_i || v_req_i || exp_q.size() != 0 || mq.size() != 0) begin
            if (wait_cnt == DRAIN_TIMEOUT) stop_failed("timeout while draining responses");
            step();
            wait_cnt++;
        end
        if (!hit_full) begin
            stop_failed("tracker never became full during the long delay phase");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vmem_share_top.sv ====
//////////////////////////////
// shared data memory port
// scalar core and vector unit on one wide bus
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vmem_share_top import vmem_share_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,

    // scalar core
    input  logic   s_req_i,
    input  addr_t  s_addr_i,
    input  logic   s_we_i,
    input  sbe_t   s_be_i,
    input  sdata_t s_wdata_i,
    output logic   s_gnt_o,
    output logic   s_rvalid_o,
    output sdata_t s_rdata_o,
    output logic   s_err_o,

    // vector unit
    input  logic   v_req_i,
    input  addr_t  v_addr_i,
    input  logic   v_we_i,
    input  vbe_t   v_be_i,
    input  vdata_t v_wdata_i,
    input  vid_t   v_id_i,
    output logic   v_gnt_o,
    output logic   v_rvalid_o,
    output vdata_t v_rdata_o,
    output logic   v_err_o,
    output vid_t   v_id_o,
    input  logic   vec_pending_load_i,
    input  logic   vec_pending_store_i,

    // memory
    output logic   mem_req_o,
    output addr_t  mem_addr_o,
    output logic   mem_we_o,
    output vbe_t   mem_be_o,
    output vdata_t mem_wdata_o,
    input  logic   mem_gnt_i,
    input  logic   mem_rvalid_i,
    input  vdata_t mem_rdata_i,
    input  logic   mem_err_i
);

    vbe_t         wide_be;
    vdata_t       wide_wdata;
    lane_t        s_lane;
    logic         push;
    track_entry_t entry;
    logic         full;

    scalar_lane_adapter u_adapter (
        .s_addr_i     (s_addr_i),
        .s_be_i       (s_be_i),
        .s_wdata_i    (s_wdata_i),
        .wide_be_o    (wide_be),
        .wide_wdata_o (wide_wdata),
        .lane_o       (s_lane)
    );

    data_arbiter u_arbiter (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .s_req_i             (s_req_i),
        .s_addr_i            (s_addr_i),
        .s_we_i              (s_we_i),
        .wide_be_i           (wide_be),
        .wide_wdata_i        (wide_wdata),
        .lane_i              (s_lane),
        .v_req_i             (v_req_i),
        .v_addr_i            (v_addr_i),
        .v_we_i              (v_we_i),
        .v_be_i              (v_be_i),
        .v_wdata_i           (v_wdata_i),
        .v_id_i              (v_id_i),
        .vec_pending_load_i  (vec_pending_load_i),
        .vec_pending_store_i (vec_pending_store_i),
        .mem_gnt_i           (mem_gnt_i),
        .full_i              (full),
        .s_gnt_o             (s_gnt_o),
        .v_gnt_o             (v_gnt_o),
        .mem_req_o           (mem_req_o),
        .mem_addr_o          (mem_addr_o),
        .mem_we_o            (mem_we_o),
        .mem_be_o            (mem_be_o),
        .mem_wdata_o         (mem_wdata_o),
        .push_o              (push),
        .entry_o             (entry)
    );

    resp_tracker u_tracker (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (push),
        .entry_i      (entry),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_err_i    (mem_err_i),
        .full_o       (full),
        .s_rvalid_o   (s_rvalid_o),
        .s_rdata_o    (s_rdata_o),
        .s_err_o      (s_err_o),
        .v_rvalid_o   (v_rvalid_o),
        .v_rdata_o    (v_rdata_o),
        .v_err_o      (v_err_o),
        .v_id_o       (v_id_o)
    );

endmodule

`default_nettype wire

// ==== rtl/resp_tracker.sv ====
//////////////////////////////
// response tracker
// in-order FIFO of outstanding transfers, routes responses
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vmem_share_defines.svh"

module resp_tracker import vmem_share_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,

    // new transfer from the arbiter
    input  logic         push_i,
    input  track_entry_t entry_i,

    // memory response
    input  logic         mem_rvalid_i,
    input  vdata_t       mem_rdata_i,
    input  logic         mem_err_i,

    output logic         full_o,

    // scalar response
    output logic         s_rvalid_o,
    output sdata_t       s_rdata_o,
    output logic         s_err_o,

    // vector response
    output logic         v_rvalid_o,
    output vdata_t       v_rdata_o,
    output logic         v_err_o,
    output vid_t         v_id_o
);

    localparam int unsigned DEPTH = `MAX_OUTSTANDING;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    track_entry_t fifo_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic         pop;
    logic         empty;
    logic         head_scalar;
    track_entry_t head;

    assign empty  = (count_q == '0);
    assign full_o = (count_q == CNT_W'(DEPTH));
    assign pop    = mem_rvalid_i;
    assign head   = fifo_q[rd_ptr_q];

    //////////////////////////////
    // FIFO storage
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            fifo_q[wr_ptr_q] <= entry_i;
        end
    end

    // pointers and fill count
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    //////////////////////////////
    // response routing
    //////////////////////////////

    // the head entry owns the response, memory answers in order
    assign head_scalar = (head.src == SRC_SCALAR);

    assign s_rvalid_o = mem_rvalid_i & head_scalar;
    assign v_rvalid_o = mem_rvalid_i & ~head_scalar;

    assign s_err_o = mem_err_i & head_scalar;
    assign v_err_o = mem_err_i & ~head_scalar;

    // scalar reads return the lane they were placed in, writes return zero
    assign s_rdata_o = head.we ? '0 : mem_rdata_i[head.lane * `SCALAR_W +: `SCALAR_W];

    assign v_rdata_o = mem_rdata_i;
    assign v_id_o    = head.id;

    //////////////////////////////
    // checks
    //////////////////////////////

    // every response must belong to a tracked transfer
    a_no_orphan_resp : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> !empty);

    // arbiter must hold back while the FIFO is full
    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o);

endmodule

`default_nettype wire

// ==== rtl/data_arbiter.sv ====
//////////////////////////////
// data arbiter
// vector priority, scalar hold rule and grant split
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vmem_share_defines.svh"

module data_arbiter import vmem_share_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    // scalar side, already widened
    input  logic                   s_req_i,
    input  logic [`ADDR_W-1:0]     s_addr_i,
    input  logic                   s_we_i,
    input  vbe_t                   wide_be_i,
    input  vdata_t                 wide_wdata_i,
    input  lane_t                  lane_i,

    // vector side
    input  logic                   v_req_i,
    input  logic [`ADDR_W-1:0]     v_addr_i,
    input  logic                   v_we_i,
    input  logic [`VMEM_W/8-1:0]   v_be_i,
    input  logic [`VMEM_W-1:0]     v_wdata_i,
    input  logic [`ID_W-1:0]       v_id_i,

    input  logic                   vec_pending_load_i,
    input  logic                   vec_pending_store_i,
    input  logic                   mem_gnt_i,
    input  logic                   full_i,

    output logic                   s_gnt_o,
    output logic                   v_gnt_o,

    output logic                   mem_req_o,
    output logic [`ADDR_W-1:0]     mem_addr_o,
    output logic                   mem_we_o,
    output logic [`VMEM_W/8-1:0]   mem_be_o,
    output logic [`VMEM_W-1:0]     mem_wdata_o,

    output logic                   push_o,
    output track_entry_t           entry_o
);

    logic s_hold;
    logic s_sel;
    logic bus_free;

    //////////////////////////////
    // arbitration
    //////////////////////////////

    // scalar waits for vector traffic and for pending vector stores,
    // a pending vector load only blocks scalar writes
    assign s_hold = v_req_i | vec_pending_store_i | (vec_pending_load_i & s_we_i);
    assign s_sel  = s_req_i & ~s_hold;

    // nothing goes out while the tracker cannot take another entry
    assign mem_req_o = (v_req_i | s_sel) & ~full_i;
    assign bus_free  = mem_gnt_i & ~full_i;

    assign v_gnt_o = v_req_i & bus_free;
    assign s_gnt_o = s_sel & bus_free;

    // winner's fields onto the bus
    always_comb begin
        if (v_req_i) begin
            mem_addr_o  = v_addr_i;
            mem_we_o    = v_we_i;
            mem_be_o    = v_be_i;
            mem_wdata_o = v_wdata_i;
        end else begin
            mem_addr_o  = s_addr_i;
            mem_we_o    = s_we_i;
            mem_be_o    = wide_be_i;
            mem_wdata_o = wide_wdata_i;
        end
    end

    //////////////////////////////
    // tracker entry
    //////////////////////////////

    assign push_o = mem_req_o & mem_gnt_i;

    assign entry_o.src  = v_req_i ? SRC_VECTOR : SRC_SCALAR;
    assign entry_o.we   = mem_we_o;
    assign entry_o.id   = v_req_i ? vid_t'(v_id_i) : vid_t'('0);
    assign entry_o.lane = v_req_i ? lane_t'('0) : lane_i;

    //////////////////////////////
    // checks
    //////////////////////////////

    // a waiting scalar request keeps its widened payload until granted
    a_scalar_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (s_req_i && !s_gnt_o) |=> (s_req_i && $stable(s_addr_i) && $stable(s_we_i)
                                   && $stable(wide_be_i) && $stable(wide_wdata_i)));

endmodule

`default_nettype wire

// ==== rtl/scalar_lane_adapter.sv ====
//////////////////////////////
// scalar lane adapter
// places a 32-bit access into its lane of the wide bus
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scalar_lane_adapter import vmem_share_pkg::*; (
    input  addr_t  s_addr_i,
    input  sbe_t   s_be_i,
    input  sdata_t s_wdata_i,

    output vbe_t   wide_be_o,
    output vdata_t wide_wdata_o,
    output lane_t  lane_o
);

    // lanes on the wide bus and where the lane index sits in the address
    localparam int unsigned NUM_LANES = $bits(vdata_t) / $bits(sdata_t);
    localparam int unsigned LANE_LSB  = $clog2($bits(sbe_t));
    localparam int unsigned LANE_BES  = $bits(sbe_t);

    lane_t lane;

    //////////////////////////////
    // lane select
    //////////////////////////////

    // address bits right above the byte offset of a scalar word
    assign lane   = s_addr_i[LANE_LSB +: $bits(lane_t)];
    assign lane_o = lane;

    //////////////////////////////
    // byte enables and data
    //////////////////////////////

    // byte enables move to the selected lane, all others stay clear
    assign wide_be_o = vbe_t'(s_be_i) << (lane * LANE_BES);

    // write data goes to every lane, the enables pick the right one
    assign wide_wdata_o = {NUM_LANES{s_wdata_i}};

endmodule

`default_nettype wire

// ==== rtl/vmem_share_pkg.sv ====
//////////////////////////////
// shared memory port types
// data, address, id, lane and tracker entries
//////////////////////////////

`default_nettype none

`include "vmem_share_defines.svh"

package vmem_share_pkg;

    // bus payloads
    typedef logic [`ADDR_W-1:0]     addr_t;
    typedef logic [`VMEM_W-1:0]     vdata_t;
    typedef logic [`VMEM_W/8-1:0]   vbe_t;
    typedef logic [`SCALAR_W-1:0]   sdata_t;
    typedef logic [`SCALAR_W/8-1:0] sbe_t;
    typedef logic [`ID_W-1:0]       vid_t;

    // scalar lane inside the wide word
    typedef logic [$clog2(`VMEM_W/`SCALAR_W)-1:0] lane_t;

    // who issued a request
    typedef enum logic {
        SRC_SCALAR = 1'b0,
        SRC_VECTOR = 1'b1
    } src_e;

    // one outstanding transfer, 8 bits
    typedef struct packed {
        src_e  src;
        logic  we;
        vid_t  id;
        lane_t lane;
    } track_entry_t;

endpackage

`default_nettype wire

// ==== rtl/vmem_share_defines.svh ====
//////////////////////////////
// shared memory port widths and depths
// sizes for the scalar, vector and memory sides
//////////////////////////////

`ifndef VMEM_SHARE_DEFINES_SVH
`define VMEM_SHARE_DEFINES_SVH

// width of the shared memory data bus
`define VMEM_W 128

// scalar core data width
`define SCALAR_W 32

// byte address width on every port
`define ADDR_W 32

// vector transaction id width
`define ID_W 4

// depth of the outstanding request FIFO
`define MAX_OUTSTANDING 8

`endif
